// File: logic/perf_pkg.sv
package perf_pkg;

	localparam int CNT_W    = 12;
	localparam int N_EVENTS = 8;
	localparam int TIMER_W  = 32;

	// sample schedule in cycles after reset
	localparam logic [TIMER_W-1:0] FIRST_SAMPLE  = 32'd500;
	localparam logic [TIMER_W-1:0] SAMPLE_PERIOD = 32'd1000;

	// record layout, three groups of tag plus six digits
	localparam int REC_LEN   = 21;
	localparam int REC_IDX_W = $clog2(REC_LEN);
	localparam int GRP_LEN   = 7;
	localparam int SNAP_W    = 6 * CNT_W;

	localparam logic [7:0] TAG_L1I = "a";
	localparam logic [7:0] TAG_L1D = "b";
	localparam logic [7:0] TAG_L2  = "c";

	// field order is shared by events and counts
	typedef struct packed {
		logic l1i_read;
		logic l1i_miss;
		logic l1d_read;
		logic l1d_write;
		logic l1d_miss;
		logic l2_read;
		logic l2_write;
		logic l2_miss;
	} perf_events_t;

	typedef struct packed {
		logic [CNT_W-1:0] l1i_read;
		logic [CNT_W-1:0] l1i_miss;
		logic [CNT_W-1:0] l1d_read;
		logic [CNT_W-1:0] l1d_write;
		logic [CNT_W-1:0] l1d_miss;
		logic [CNT_W-1:0] l2_read;
		logic [CNT_W-1:0] l2_write;
		logic [CNT_W-1:0] l2_miss;
	} perf_counts_t;

	// msb first, in the order the digits go out
	typedef struct packed {
		logic [CNT_W-1:0] l1i_miss;
		logic [CNT_W-1:0] l1i_read;
		logic [CNT_W-1:0] l1d_miss;
		logic [CNT_W-1:0] l1d_access;
		logic [CNT_W-1:0] l2_miss;
		logic [CNT_W-1:0] l2_access;
	} perf_snap_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		REQ,
		WAIT_ACK_LOW
	} ser_state_t;

endpackage

// File: logic/event_edge_counter.sv
module event_edge_counter (
	input  logic                   clk,
	input  logic                   rstn,
	input  perf_pkg::perf_events_t events_i,
	output perf_pkg::perf_counts_t counts_o
);

	import perf_pkg::*;

	logic [N_EVENTS-1:0] ev_now;
	logic [N_EVENTS-1:0] ev_prev_q;
	logic [N_EVENTS-1:0] ev_rise;

	// one wrapping counter per strobe
	logic [N_EVENTS-1:0][CNT_W-1:0] cnt_q;

	// bit 7 is l1i_read, same order as the struct
	assign ev_now = events_i;

	// only a low to high change counts
	assign ev_rise = ev_now & ~ev_prev_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ev_prev_q <= '0;
		end else begin
			ev_prev_q <= ev_now;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < N_EVENTS; i++) begin
				if (ev_rise[i]) begin
					// wraps at 4096
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	// element 7 lands in the top field, l1i_read
	assign counts_o = perf_counts_t'(cnt_q);

endmodule

// File: logic/perf_snapshot.sv
module perf_snapshot #(
	parameter logic [perf_pkg::TIMER_W-1:0] FIRST  = perf_pkg::FIRST_SAMPLE,
	parameter logic [perf_pkg::TIMER_W-1:0] PERIOD = perf_pkg::SAMPLE_PERIOD
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  perf_pkg::perf_counts_t counts_i,
	input  logic                   snap_take_i,
	output perf_pkg::perf_snap_t   snap_o,
	output logic                   snap_valid_o
);

	import perf_pkg::*;

	logic [TIMER_W-1:0] timer_q;
	logic [TIMER_W-1:0] next_q;
	logic               sample;

	perf_snap_t snap_d;
	perf_snap_t snap_q;
	logic       valid_q;

	// free-running cycle count since reset
	assign sample = (timer_q == next_q);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			timer_q <= '0;
			next_q  <= FIRST;
		end else begin
			timer_q <= timer_q + 1'b1;
			if (sample) begin
				next_q <= next_q + PERIOD;
			end
		end
	end

	always_comb begin
		snap_d.l1i_miss   = counts_i.l1i_miss;
		snap_d.l1i_read   = counts_i.l1i_read;
		snap_d.l1d_miss   = counts_i.l1d_miss;
		snap_d.l2_miss    = counts_i.l2_miss;
		// access sums truncated to counter width
		snap_d.l1d_access = CNT_W'(counts_i.l1d_read + counts_i.l1d_write);
		snap_d.l2_access  = CNT_W'(counts_i.l2_read + counts_i.l2_write);
	end

	// a newer sample simply overwrites a pending one
	always_ff @(posedge clk) begin
		if (sample) begin
			snap_q <= snap_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else if (sample) begin
			valid_q <= 1'b1;
		end else if (snap_take_i) begin
			valid_q <= 1'b0;
		end
	end

	assign snap_o       = snap_q;
	assign snap_valid_o = valid_q;

endmodule

// File: logic/hex_record_serializer.sv
module hex_record_serializer (
	input  logic                 clk,
	input  logic                 rstn,
	input  perf_pkg::perf_snap_t snap_i,
	input  logic                 snap_valid_i,
	input  logic                 ack_i,
	output logic                 snap_take_o,
	output logic [7:0]           byte_o,
	output logic                 req_o
);

	import perf_pkg::*;

	localparam logic [REC_IDX_W-1:0] IDX_LAST = REC_IDX_W'(REC_LEN - 1);

	ser_state_t state_q;

	logic [REC_IDX_W-1:0] idx_q;
	logic [SNAP_W-1:0]    nib_sr_q;
	logic [7:0]           byte_d;
	logic [7:0]           byte_q;
	logic                 is_tag;
	logic                 req_q;

	// 0-9 to '0'-'9', 10-15 to 'A'-'F'
	function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
		logic [7:0] wide;
		wide = {4'h0, nib};
		if (nib < 4'd10) begin
			return 8'h30 + wide;
		end
		return 8'h37 + wide;
	endfunction

	// tags at 0, 7 and 14, digits elsewhere
	always_comb begin
		is_tag = 1'b1;
		case (idx_q)
			REC_IDX_W'(0): begin
				byte_d = TAG_L1I;
			end
			REC_IDX_W'(GRP_LEN): begin
				byte_d = TAG_L1D;
			end
			REC_IDX_W'(2 * GRP_LEN): begin
				byte_d = TAG_L2;
			end
			default: begin
				is_tag = 1'b0;
				byte_d = hex_ascii(nib_sr_q[SNAP_W-1 -: 4]);
			end
		endcase
	end

	assign snap_take_o = (state_q == IDLE) && snap_valid_i;

	// snapshot digits leave msb first, so a left shift walks the record
	always_ff @(posedge clk) begin
		if (snap_take_o) begin
			nib_sr_q <= snap_i;
		end else if (state_q == LOAD && !is_tag) begin
			nib_sr_q <= nib_sr_q << 4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= IDLE;
			idx_q   <= '0;
			byte_q  <= '0;
			req_q   <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (snap_take_o) begin
						idx_q   <= '0;
						state_q <= LOAD;
					end
				end
				LOAD: begin
					// byte set up together with req, held until next load
					byte_q  <= byte_d;
					req_q   <= 1'b1;
					state_q <= REQ;
				end
				REQ: begin
					if (ack_i) begin
						req_q   <= 1'b0;
						state_q <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: begin
					if (!ack_i) begin
						if (idx_q == IDX_LAST) begin
							state_q <= IDLE;
						end else begin
							idx_q   <= idx_q + 1'b1;
							state_q <= LOAD;
						end
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	assign byte_o = byte_q;
	assign req_o  = req_q;

endmodule

// File: logic/cache_perf_monitor.sv
module cache_perf_monitor #(
	parameter logic [perf_pkg::TIMER_W-1:0] FIRST  = perf_pkg::FIRST_SAMPLE,
	parameter logic [perf_pkg::TIMER_W-1:0] PERIOD = perf_pkg::SAMPLE_PERIOD
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  perf_pkg::perf_events_t events_i,
	input  logic                   ack_i,
	output logic [7:0]             byte_o,
	output logic                   req_o
);

	import perf_pkg::*;

	perf_counts_t counts;
	perf_snap_t   snap;
	logic         snap_valid;
	logic         snap_take;

	event_edge_counter u_counter (
		.clk      (clk),
		.rstn     (rstn),
		.events_i (events_i),
		.counts_o (counts)
	);

	// sample timer and capture
	perf_snapshot #(
		.FIRST  (FIRST),
		.PERIOD (PERIOD)
	) u_snapshot (
		.clk          (clk),
		.rstn         (rstn),
		.counts_i     (counts),
		.snap_take_i  (snap_take),
		.snap_o       (snap),
		.snap_valid_o (snap_valid)
	);

	// ascii record out over req/ack
	hex_record_serializer u_serializer (
		.clk          (clk),
		.rstn         (rstn),
		.snap_i       (snap),
		.snap_valid_i (snap_valid),
		.ack_i        (ack_i),
		.snap_take_o  (snap_take),
		.byte_o       (byte_o),
		.req_o        (req_o)
	);

endmodule

// File: test/perf_tb_tasks.svh
task automatic stop_with_error(input string what);
	$display("Error at %0t ns: %s", $time, what);
	$display("Checks failed");
	$fatal(1, "stopping on the first error");
endtask

task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		$display("Checks failed");
		$fatal(1, "stopping on the first error");
	end
endtask

// returns on a falling clock edge with req_o at the wanted level
task automatic wait_req(input logic level, input int limit, input string what);
	int n;
	n = 0;
	@(negedge clk);
	while (req_o !== level) begin
		if (n >= limit) begin
			stop_with_error($sformatf("timed out waiting for %s", what));
		end else begin
			n++;
			@(negedge clk);
		end
	end
endtask

task automatic count_pulses(input logic [7:0] mask);
	for (int b = 0; b < 8; b++) begin
		if (mask[b]) begin
			m_cnt[b]++;
		end
	end
endtask

task automatic pulse_events(input logic [7:0] mask, input int n);
	int gap;
	for (int k = 0; k < n; k++) begin
		gap = 1 + ($urandom % 3);
		@(posedge clk);
		events_i <= perf_events_t'(mask);
		@(posedge clk);
		events_i <= '0;
		repeat (gap - 1) @(posedge clk);
		count_pulses(mask);
	end
endtask

function automatic logic [7:0] hex_digit(input int value);
	string digits;
	digits = "0123456789ABCDEF";
	return digits[value & 15];
endfunction

// tag, three miss digits, three digits of the second count
function automatic void put_group(input int base, input logic [7:0] tag, input int miss,
		input int other);
	exp_rec[base] = tag;
	for (int k = 0; k < 3; k++) begin
		exp_rec[base + 1 + k] = hex_digit(miss >> (8 - 4 * k));
		exp_rec[base + 4 + k] = hex_digit(other >> (8 - 4 * k));
	end
endfunction

function automatic void build_expected();
	put_group(0, "a", m_cnt[6], m_cnt[7]);
	put_group(7, "b", m_cnt[3], m_cnt[5] + m_cnt[4]);
	put_group(14, "c", m_cnt[0], m_cnt[2] + m_cnt[1]);
endfunction

task automatic receive_record();
	for (int i = 0; i < REC_LEN; i++) begin
		wait_req(1'b1, (i == 0) ? IDLE_LIMIT : BYTE_LIMIT, "req_o of the next byte");
		got_rec[i] = byte_o;
		wait_req(1'b0, BYTE_LIMIT, "req_o to drop");
	end
endtask

task automatic expect_record(input string what);
	build_expected();
	receive_record();
	rec_no++;
	for (int i = 0; i < REC_LEN; i++) begin
		check(got_rec[i], exp_rec[i], $sformatf("%s, record %0d byte %0d", what, rec_no, i));
	end
endtask

// sink side of the four-phase handshake
task automatic respond_ack();
	int unsigned delay;
	forever begin
		wait_req(1'b1, IDLE_LIMIT, "req_o at the ack responder");
		delay = slow_ack ? 4 + ($urandom % 14) : $urandom % 3;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		ack_i <= 1'b1;
		wait_req(1'b0, BYTE_LIMIT, "req_o to drop after ack");
		@(posedge clk);
		ack_i <= 1'b0;
	end
endtask

task automatic watch_handshake();
	logic       req_prev;
	logic [7:0] byte_prev;
	req_prev  = 1'b0;
	byte_prev = 8'h00;
	forever begin
		@(negedge clk);
		if (req_o && cyc < TB_FIRST) begin
			stop_with_error("req_o rose before the first sample point");
		end else if (req_o && !req_prev && ack_i) begin
			stop_with_error("req_o rose while ack_i was still high");
		end else if (req_o && req_prev && byte_o !== byte_prev) begin
			stop_with_error("byte_o changed while req_o was high");
		end else begin
			req_prev  = req_o;
			byte_prev = byte_o;
		end
	end
endtask

// File: test/tb_cache_perf_monitor.sv
module tb_cache_perf_monitor;

	timeunit 1ns;
	timeprecision 1ps;

	import perf_pkg::*;

	localparam int          TB_FIRST   = 200;
	localparam int          TB_PERIOD  = 1500;
	localparam int unsigned SEED       = 32'h7c7a_2784;
	localparam int          IDLE_LIMIT = 2 * TB_PERIOD;
	localparam int          BYTE_LIMIT = 64;

	// strobe masks in perf_events_t bit order
	localparam logic [7:0] EV_L1I_READ  = 8'h80;
	localparam logic [7:0] EV_L1I_MISS  = 8'h40;
	localparam logic [7:0] EV_L1D_READ  = 8'h20;
	localparam logic [7:0] EV_L1D_WRITE = 8'h10;
	localparam logic [7:0] EV_L1D_MISS  = 8'h08;
	localparam logic [7:0] EV_L2_READ   = 8'h04;
	localparam logic [7:0] EV_L2_WRITE  = 8'h02;
	localparam logic [7:0] EV_L2_MISS   = 8'h01;

	logic         clk;
	logic         rstn;
	perf_events_t events_i;
	logic         ack_i;
	logic [7:0]   byte_o;
	logic         req_o;

	logic       slow_ack;
	int         cyc;
	int         rec_no;
	int         m_cnt [8];
	logic [7:0] got_rec [REC_LEN];
	logic [7:0] exp_rec [REC_LEN];

	cache_perf_monitor #(
		.FIRST  (32'(TB_FIRST)),
		.PERIOD (32'(TB_PERIOD))
	) dut0 (
		.clk      (clk),
		.rstn     (rstn),
		.events_i (events_i),
		.ack_i    (ack_i),
		.byte_o   (byte_o),
		.req_o    (req_o)
	);

	`include "perf_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// cycles since reset release, lines up with the sample timer
	always @(posedge clk) begin
		if (!rstn) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	task automatic reset_idle_test();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check(req_o, 1'b0, "req_o after reset");
			check(byte_o, 8'h00, "byte_o after reset");
		end
	endtask

	task automatic known_counts_test();
		pulse_events(EV_L1I_READ, 5);
		pulse_events(EV_L1I_MISS, 2);
		pulse_events(EV_L1D_READ, 4);
		pulse_events(EV_L1D_WRITE, 3);
		pulse_events(EV_L1D_MISS, 1);
		pulse_events(EV_L2_READ, 2);
		pulse_events(EV_L2_WRITE, 2);
		pulse_events(EV_L2_MISS, 1);
		if (cyc >= TB_FIRST - 8) begin
			stop_with_error("the pulses ran into the first sample point");
		end
		expect_record("known counts");
	endtask

	task automatic held_strobe_test();
		@(posedge clk);
		events_i <= perf_events_t'(EV_L1D_MISS);
		repeat (40) @(posedge clk);
		events_i <= '0;
		count_pulses(EV_L1D_MISS);
		expect_record("held strobe");
	endtask

	task automatic hex_letters_test();
		pulse_events(8'hFF, 27);
		pulse_events(EV_L1I_MISS, 9);
		expect_record("hex letters");
	endtask

	task automatic slow_ack_test();
		slow_ack = 1'b1;
		pulse_events(EV_L2_READ | EV_L1D_WRITE, 3);
		expect_record("slow ack first");
		pulse_events(EV_L1I_READ, 5);
		expect_record("slow ack second");
		slow_ack = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		rstn     <= 1'b0;
		events_i <= '0;
		ack_i    <= 1'b0;
		slow_ack = 1'b0;
		rec_no   = 0;
		foreach (m_cnt[i]) begin
			m_cnt[i] = 0;
		end
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		fork
			respond_ack();
			watch_handshake();
		join_none
		reset_idle_test();
		known_counts_test();
		held_strobe_test();
		hex_letters_test();
		slow_ack_test();
		$display("All checks passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+test
logic/perf_pkg.sv
logic/event_edge_counter.sv
logic/perf_snapshot.sv
logic/hex_record_serializer.sv
logic/cache_perf_monitor.sv
test/tb_cache_perf_monitor.sv

// File: Bender.yml
package:
  name: cache_perf_monitor

sources:
  - files:
      - logic/perf_pkg.sv
      - logic/event_edge_counter.sv
      - logic/perf_snapshot.sv
      - logic/hex_record_serializer.sv
      - logic/cache_perf_monitor.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cache_perf_monitor.sv
